// File: hdl/vid_pkg.sv
package vid_pkg;

    // chip variants, bit 0 marks the PAL parts
    typedef enum logic [1:0] {
        ntsc_r8   = 2'b00,
        pal_r1    = 2'b01,
        ntsc_r56a = 2'b10,
        pal_r3    = 2'b11
    } chip_e;

    // luma source picked per raster step
    typedef enum logic [1:0] {
        sync_tip,
        blank,
        marker,
        pixel
    } luma_sel_e;

    // color burst sequencer states
    typedef enum logic [1:0] {
        burst_idle,   // waiting for a line change
        burst_armed,  // line changed, waiting for the burst start x
        burst_run     // emitting burst_samples clocks of burst
    } burst_state_e;

    // horizontal tables, indexed by chip_e (ntsc, pal, ntsc, pal)
    localparam logic [9:0] hsync_start [4]    = '{10'd8, 10'd7, 10'd8, 10'd7};
    localparam logic [9:0] hsync_end [4]      = '{10'd45, 10'd44, 10'd45, 10'd44};
    localparam logic [9:0] hvisible_start [4] = '{10'd96, 10'd91, 10'd96, 10'd91};
    localparam logic [9:0] half_line_x [4]    = '{10'd40, 10'd39, 10'd40, 10'd39};

    // vertical tables, line numbers
    localparam logic [8:0] vvisible_end [4]   = '{9'd13, 9'd300, 9'd13, 9'd300};
    localparam logic [8:0] vblank_start [4]   = '{9'd14, 9'd301, 9'd14, 9'd301};
    localparam logic [8:0] vblank_end [4]     = '{9'd22, 9'd309, 9'd22, 9'd309};
    localparam logic [8:0] vvisible_start [4] = '{9'd23, 9'd310, 9'd23, 9'd310};

    localparam logic [9:0] eq_width = 10'd18;  // equalization pulse, raster steps
    localparam logic [9:0] se_width = 10'd30;  // serration pulse, raster steps

    // luma levels
    localparam logic [5:0] blank_level_ntsc = 6'd24;
    localparam logic [5:0] blank_level_pal  = 6'd8;
    localparam logic [5:0] white_burst      = 6'd59;  // first visible pixel marker

    // color burst
    localparam logic [3:0] burst_amplitude      = 4'd12;
    localparam logic [7:0] burst_samples        = 8'd144;  // 9 periods x 16 samples
    localparam logic [9:0] burst_start_ntsc     = 10'd50;
    localparam logic [9:0] burst_start_pal      = 10'd49;
    localparam logic [7:0] burst_phase_ntsc     = 8'd128;  // 180 deg
    localparam logic [7:0] burst_phase_pal_even = 8'd96;   // 135 deg
    localparam logic [7:0] burst_phase_pal_odd  = 8'd160;  // -135 deg

    localparam logic [5:0] chroma_zero = 6'd32;  // unmodulated chroma level

    // 255 * sin(k * 90deg / 16), k = 0..16
    localparam logic [7:0] sine_quarter [17] = '{
        8'd0,   8'd25,  8'd50,  8'd74,  8'd98,  8'd120, 8'd142, 8'd162,
        8'd180, 8'd197, 8'd212, 8'd225, 8'd236, 8'd244, 8'd250, 8'd254,
        8'd255
    };

endpackage

// File: hdl/raster_if.sv
`timescale 1ns/100ps

// decoded raster flags, one register stage after the raster position
interface raster_if;
    logic hsync;       // inside horizontal sync
    logic vsync_zone;  // inside vertical blanking
    logic active;      // visible area
    logic pulse_low;   // eq or serration pulse low on a blanking line
    logic blank_line;  // vblank_start .. vblank_end
    logic marker;      // white marker pixel position
    logic new_line;    // one clock strobe on raster_y change
    logic odd_line;    // raster_y[0]
    logic pal;         // chip[0]

    modport decoder (output hsync, vsync_zone, active, pulse_low, blank_line,
                     marker, new_line, odd_line, pal);
    modport luma (input hsync, active, pulse_low, blank_line, marker, pal);
    modport chroma (input vsync_zone, active, marker, new_line, odd_line, pal);
endinterface

// File: hdl/raster_window.sv
`timescale 1ns/100ps

module raster_window import vid_pkg::*; (
    input  logic       clk_col16x,
    input  logic       reset,
    input  chip_e      chip,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_y,
    input  logic       white_line,
    raster_if.decoder  win
);
    logic [9:0] hs_start;
    logic [9:0] hs_end;
    logic [9:0] hv_start;
    logic [9:0] half_x;
    logic [8:0] vv_end;
    logic [8:0] vb_start;
    logic [8:0] vb_end;
    logic [8:0] vv_start;
    logic [8:0] prev_y;    // last sampled line, for the new_line strobe
    logic [8:0] line_ofs;  // line offset inside vertical blanking
    logic       eq_c;
    logic       se_c;
    logic       blank_line_c;
    logic       vzone_c;
    logic       vinvis_c;

    assign hs_start = hsync_start[chip];
    assign hs_end   = hsync_end[chip];
    assign hv_start = hvisible_start[chip];
    assign half_x   = half_line_x[chip];
    assign vv_end   = vvisible_end[chip];
    assign vb_start = vblank_start[chip];
    assign vb_end   = vblank_end[chip];
    assign vv_start = vvisible_start[chip];

    assign line_ofs = raster_y - vb_start;
    assign blank_line_c = (raster_y >= vb_start) && (raster_y <= vb_end);

    // two short pulses per line, one at sync start and one at the half line
    assign eq_c = (raster_x >= hs_start && raster_x < hs_start + eq_width) ||
                  (raster_x >= half_x && raster_x < half_x + eq_width);
    // broad pulses, low for most of each half line
    assign se_c = (raster_x >= hs_start && raster_x < hs_start + se_width) ||
                  (raster_x >= half_x && raster_x < half_x + se_width);

    // blanking zone opens at hsync of vblank_start, closes at hsync end of vblank_end
    assign vzone_c = ((raster_y == vb_start && raster_x >= hs_start) || raster_y > vb_start) &&
                     (raster_y < vb_end || (raster_y == vb_end && raster_x < hs_end));
    // vertical invisible window, visible area ends at x 0
    assign vinvis_c = (raster_y >= vv_end) &&
                      ((raster_y == vv_start && raster_x <= hv_start) || raster_y < vv_start);

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            win.hsync      <= 1'b0;
            win.vsync_zone <= 1'b0;
            win.active     <= 1'b0;
            win.pulse_low  <= 1'b0;
            win.blank_line <= 1'b0;
            win.marker     <= 1'b0;
            win.new_line   <= 1'b0;
            win.odd_line   <= 1'b0;
            win.pal        <= 1'b0;
            prev_y         <= '0;
        end else begin
            win.hsync      <= (raster_x >= hs_start) && (raster_x < hs_end);
            win.vsync_zone <= vzone_c;
            win.active     <= !((raster_x < hv_start) || vinvis_c);
            // offsets 3..5 carry serration, the rest equalization
            win.pulse_low  <= blank_line_c && ((line_ofs >= 9'd3 && line_ofs <= 9'd5) ? se_c : eq_c);
            win.blank_line <= blank_line_c;
            win.marker     <= (raster_x == hv_start) && white_line;
            win.new_line   <= (raster_y != prev_y);
            win.odd_line   <= raster_y[0];
            win.pal        <= chip[0];
            prev_y         <= raster_y;
        end
    end
endmodule

// File: hdl/luma_gen.sv
`timescale 1ns/100ps

module luma_gen import vid_pkg::*; (
    input  logic       clk_col16x,
    input  logic       reset,
    raster_if.luma     rw,
    input  logic [5:0] luma_reg,    // pixel luma from the color registers
    output logic [5:0] luma_level,
    output logic       sink         // pulls current during sync tips
);
    luma_sel_e  sel;
    logic [5:0] blank_lvl;
    logic [5:0] luma_reg_d;  // pixel luma lined up with the flags

    assign blank_lvl = rw.pal ? blank_level_pal : blank_level_ntsc;

    // priority: blanking lines, hsync, border, marker, pixel
    always_comb begin
        if (rw.blank_line)
            sel = rw.pulse_low ? sync_tip : blank;
        else if (rw.hsync)
            sel = sync_tip;
        else if (!rw.active)
            sel = blank;
        else if (rw.marker)
            sel = marker;  // white pixel at hvisible_start
        else
            sel = pixel;
    end

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            luma_level <= 6'd0;
            sink       <= 1'b0;
            luma_reg_d <= 6'd0;
        end else begin
            luma_reg_d <= luma_reg;
            sink <= (sel == sync_tip);
            case (sel)
                sync_tip: luma_level <= 6'd0;
                blank:    luma_level <= blank_lvl;
                marker:   luma_level <= white_burst;
                default:  luma_level <= luma_reg_d;
            endcase
        end
    end
endmodule

// File: hdl/chroma_gen.sv
`timescale 1ns/100ps

module chroma_gen import vid_pkg::*; (
    input  logic       clk_col16x,
    input  logic       reset,
    raster_if.chroma   rw,
    input  logic [9:0] raster_x,
    input  logic [7:0] phase_reg,   // hue offset from the color registers
    input  logic [3:0] amp_reg,     // saturation code from the color registers
    output logic [5:0] chroma_level
);
    logic [3:0]   phase_cnt;    // 16 samples per subcarrier period
    burst_state_e burst_state;
    logic [7:0]   burst_cnt;
    logic [9:0]   x_d;          // raster_x aligned with the flags
    logic [7:0]   phase_d;      // color registers aligned with the flags
    logic [3:0]   amp_d;
    logic [9:0]   burst_x;
    logic         in_burst;
    logic [3:0]   amp_sel;
    logic [7:0]   phase_ofs;
    logic [7:0]   wave_addr;
    logic [3:0]   amp1;         // stage 1, address
    logic [7:0]   addr1;
    logic [4:0]   tbl_idx;
    logic [3:0]   amp2;         // stage 2, table read
    logic [7:0]   sine_mag;
    logic         neg2;
    logic [11:0]  product;
    logic [4:0]   dev;

    assign burst_x  = rw.pal ? burst_start_pal : burst_start_ntsc;
    assign in_burst = (burst_state == burst_run);

    // vblank kills everything, border carries only the burst
    assign amp_sel = rw.vsync_zone ? 4'd0 :
                     rw.active ? (rw.marker ? 4'd0 : amp_d) :
                     in_burst ? burst_amplitude : 4'd0;

    always_comb begin
        if (rw.active) begin
            if (rw.marker)
                phase_ofs = 8'd0;
            else if (rw.pal && rw.odd_line)
                phase_ofs = ~phase_d;  // PAL swings the V phase each line
            else
                phase_ofs = phase_d;
        end else if (rw.pal) begin
            phase_ofs = rw.odd_line ? burst_phase_pal_odd : burst_phase_pal_even;
        end else begin
            phase_ofs = burst_phase_ntsc;
        end
    end

    assign wave_addr = {phase_cnt, 4'b0000} + phase_ofs;
    // fold the quadrant back onto the quarter table, 4 address steps per entry
    assign tbl_idx = addr1[6] ? 5'd16 - {1'b0, addr1[5:2]} : {1'b0, addr1[5:2]};
    assign product = sine_mag * amp2;
    assign dev     = product[11:7];  // peak 29, keeps 32 +/- dev inside 6 bits

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            phase_cnt    <= 4'd0;
            burst_state  <= burst_idle;
            burst_cnt    <= 8'd0;
            amp1         <= 4'd0;
            amp2         <= 4'd0;
            chroma_level <= chroma_zero;
        end else begin
            phase_cnt <= phase_cnt + 4'd1;
            case (burst_state)
                burst_idle: if (rw.new_line) burst_state <= burst_armed;
                burst_armed: if (x_d >= burst_x) begin
                    burst_state <= burst_run;
                    burst_cnt   <= 8'd0;
                end
                default: begin
                    burst_cnt <= burst_cnt + 8'd1;
                    if (burst_cnt == burst_samples - 8'd1)
                        burst_state <= burst_idle;
                end
            endcase
            amp1 <= amp_sel;
            amp2 <= amp1;
            // flat whenever the amplitude that fed this sample was zero
            chroma_level <= (amp2 == 4'd0) ? chroma_zero :
                            neg2 ? chroma_zero - {1'b0, dev} : chroma_zero + {1'b0, dev};
        end
    end

    // datapath stages
    always_ff @(posedge clk_col16x) begin
        x_d      <= raster_x;
        phase_d  <= phase_reg;
        amp_d    <= amp_reg;
        addr1    <= wave_addr;
        sine_mag <= sine_quarter[tbl_idx];
        neg2     <= addr1[7];  // second half of the period is negative
    end
endmodule

// File: hdl/composite_mix.sv
`timescale 1ns/100ps

module composite_mix (
    input  logic       clk_col16x,
    input  logic       reset,
    input  logic [5:0] luma_level,
    input  logic       sink,
    input  logic [5:0] chroma_level,
    output logic [5:0] luma_out,
    output logic       luma_sink,
    output logic [5:0] chroma_out,
    output logic [5:0] composite_out
);
    logic [5:0] luma_d1;
    logic [5:0] luma_d2;
    logic       sink_d1;
    logic       sink_d2;
    logic [7:0] sum;  // luma + chroma, still carrying the 32 offset

    assign sum = {2'b00, luma_d2} + {2'b00, chroma_level};

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            luma_d1       <= 6'd0;
            luma_d2       <= 6'd0;
            sink_d1       <= 1'b0;
            sink_d2       <= 1'b0;
            luma_out      <= 6'd0;
            luma_sink     <= 1'b0;
            chroma_out    <= 6'd32;
            composite_out <= 6'd0;
        end else begin
            luma_d1   <= luma_level;  // two stages to match chroma latency
            luma_d2   <= luma_d1;
            sink_d1   <= sink;
            sink_d2   <= sink_d1;
            luma_out  <= luma_d2;
            luma_sink <= sink_d2;
            chroma_out <= chroma_level;
            if (sink_d2 || sum < 8'd32)
                composite_out <= 6'd0;    // sync tip or underflow
            else if (sum > 8'd95)
                composite_out <= 6'd63;   // clamp at full scale
            else
                composite_out <= sum[5:0] - 6'd32;
        end
    end
endmodule

// File: hdl/comp_video_top.sv
`timescale 1ns/100ps

module comp_video_top import vid_pkg::*; (
    input  logic       clk_col16x,
    input  logic       reset,
    input  chip_e      chip,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_y,
    input  logic       white_line,
    input  logic [5:0] luma_reg,
    input  logic [7:0] phase_reg,
    input  logic [3:0] amp_reg,
    output logic [5:0] luma_out,
    output logic       luma_sink,
    output logic [5:0] chroma_out,
    output logic [5:0] composite_out
);
    logic [5:0] luma_level;
    logic       sink;
    logic [5:0] chroma_level;

    raster_if rif ();  // decoded flags shared by both generators

    raster_window u_window (
        .clk_col16x (clk_col16x),
        .reset      (reset),
        .chip       (chip),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .white_line (white_line),
        .win        (rif.decoder)
    );

    luma_gen u_luma (
        .clk_col16x (clk_col16x),
        .reset      (reset),
        .rw         (rif.luma),
        .luma_reg   (luma_reg),
        .luma_level (luma_level),
        .sink       (sink)
    );

    chroma_gen u_chroma (
        .clk_col16x   (clk_col16x),
        .reset        (reset),
        .rw           (rif.chroma),
        .raster_x     (raster_x),
        .phase_reg    (phase_reg),
        .amp_reg      (amp_reg),
        .chroma_level (chroma_level)
    );

    composite_mix u_mix (
        .clk_col16x    (clk_col16x),
        .reset         (reset),
        .luma_level    (luma_level),
        .sink          (sink),
        .chroma_level  (chroma_level),
        .luma_out      (luma_out),
        .luma_sink     (luma_sink),
        .chroma_out    (chroma_out),
        .composite_out (composite_out)
    );
endmodule

// File: tests/comp_checker.sv
`timescale 1ns/100ps

module comp_checker (
    input  logic       clk_col16x,
    input  logic       reset,
    input  logic [5:0] luma_out,
    input  logic       luma_sink,
    input  logic [5:0] chroma_out,
    input  logic [5:0] composite_out,
    input  logic       exp_valid,
    input  logic [5:0] exp_luma,
    input  logic       exp_sink,
    input  logic       exp_mod,    // 1 for a modulated chroma segment
    input  logic [7:0] exp_seg,    // row number, restarts the 16 clock window
    output int         errors,
    output int         checks
);
    int         err_cnt = 0;
    int         chk_cnt = 0;
    logic [5:0] win_buf [16];  // chroma samples of one subcarrier period
    int         win_n = 0;
    int         cur_seg = -1;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // luma plus chroma around its 32 offset, limited to 6 bits, dark on sync
    function automatic int clamp_composite(input int l, input int c, input logic s);
        int v;
        v = l + c - 32;
        if (s)
            v = 0;
        else if (v < 0)
            v = 0;
        else if (v > 63)
            v = 63;
        return v;
    endfunction

    task automatic check_window();
        int   sum;
        logic same;
        sum  = 0;
        same = 1'b1;
        for (int i = 0; i < 16; i++) begin
            sum += int'(win_buf[i]);
            if (win_buf[i] != win_buf[0])
                same = 1'b0;
        end
        if (same) begin
            $display("mismatch at %0t: chroma_out stuck at %0d over a period", $time, win_buf[0]);
            err_cnt++;
        end
        if (sum < 16 * 31 || sum > 16 * 33) begin  // mean must sit within 1 of 32
            $display("mismatch at %0t: chroma mean %0d/16 not near 32", $time, sum);
            err_cnt++;
        end
    endtask

    // sample on the falling edge, well away from the registers
    always @(negedge clk_col16x) begin
        if (reset) begin
            if (luma_out != 6'd0 || luma_sink || chroma_out != 6'd32 || composite_out != 6'd0) begin
                $display("mismatch at %0t: reset values luma %0d sink %0b chroma %0d comp %0d",
                         $time, luma_out, luma_sink, chroma_out, composite_out);
                err_cnt++;
            end
            chk_cnt++;
        end else if (exp_valid) begin
            chk_cnt++;
            if (luma_out != exp_luma) begin
                $display("mismatch at %0t: luma_out %0d, expected %0d", $time, luma_out, exp_luma);
                err_cnt++;
            end
            if (luma_sink != exp_sink) begin
                $display("mismatch at %0t: luma_sink %0b, expected %0b", $time, luma_sink, exp_sink);
                err_cnt++;
            end
            if (int'(composite_out) != clamp_composite(int'(luma_out), int'(chroma_out), luma_sink)) begin
                $display("mismatch at %0t: composite_out %0d for luma %0d chroma %0d sink %0b",
                         $time, composite_out, luma_out, chroma_out, luma_sink);
                err_cnt++;
            end
            if (int'(exp_seg) != cur_seg)
                win_n = 0;  // new segment, new window
            cur_seg = int'(exp_seg);
            if (!exp_mod) begin
                if (chroma_out != 6'd32) begin
                    $display("mismatch at %0t: chroma_out %0d, expected flat 32", $time, chroma_out);
                    err_cnt++;
                end
            end else begin
                win_buf[win_n] = chroma_out;
                win_n++;
                if (win_n == 16) begin
                    check_window();
                    win_n = 0;
                end
            end
        end
    end
endmodule

// File: tests/tb_comp_video.sv
`timescale 1ns/100ps

module tb_comp_video import vid_pkg::*; ();
    logic       clk_col16x;
    logic       reset;
    chip_e      chip;
    logic [9:0] raster_x;
    logic [8:0] raster_y;
    logic       white_line;
    logic [5:0] luma_reg;
    logic [7:0] phase_reg;
    logic [3:0] amp_reg;
    logic [5:0] luma_out;
    logic       luma_sink;
    logic [5:0] chroma_out;
    logic [5:0] composite_out;

    int row_f [64][12];   // chip line xs xe hold wl luma phase amp exp_luma exp_sink mod
    int n_rows = 0;
    int limit_clocks = 0; // watchdog budget, set once the rows are loaded
    int errors;
    int checks;

    // expectation for the input driven at this edge, then five delay stages
    logic       exp_valid_c;
    logic [5:0] exp_luma_c;
    logic       exp_sink_c;
    logic       exp_mod_c;
    logic [7:0] exp_seg_c;
    logic       exp_valid [1:5];
    logic [5:0] exp_luma [1:5];
    logic       exp_sink [1:5];
    logic       exp_mod [1:5];
    logic [7:0] exp_seg [1:5];

    comp_video_top dut (
        .clk_col16x    (clk_col16x),
        .reset         (reset),
        .chip          (chip),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .white_line    (white_line),
        .luma_reg      (luma_reg),
        .phase_reg     (phase_reg),
        .amp_reg       (amp_reg),
        .luma_out      (luma_out),
        .luma_sink     (luma_sink),
        .chroma_out    (chroma_out),
        .composite_out (composite_out)
    );

    comp_checker u_checker (
        .clk_col16x    (clk_col16x),
        .reset         (reset),
        .luma_out      (luma_out),
        .luma_sink     (luma_sink),
        .chroma_out    (chroma_out),
        .composite_out (composite_out),
        .exp_valid     (exp_valid[5]),
        .exp_luma      (exp_luma[5]),
        .exp_sink      (exp_sink[5]),
        .exp_mod       (exp_mod[5]),
        .exp_seg       (exp_seg[5]),
        .errors        (errors),
        .checks        (checks)
    );

    initial begin
        clk_col16x = 1'b0;
        forever #20 clk_col16x = ~clk_col16x;  // 40 ns period
    end

    always @(posedge clk_col16x) begin
        exp_valid[1] <= exp_valid_c;
        exp_luma[1]  <= exp_luma_c;
        exp_sink[1]  <= exp_sink_c;
        exp_mod[1]   <= exp_mod_c;
        exp_seg[1]   <= exp_seg_c;
        for (int i = 2; i <= 5; i++) begin
            exp_valid[i] <= exp_valid[i-1];
            exp_luma[i]  <= exp_luma[i-1];
            exp_sink[i]  <= exp_sink[i-1];
            exp_mod[i]   <= exp_mod[i-1];
            exp_seg[i]   <= exp_seg[i-1];
        end
    end

    // watchdog, armed once the total length of the rows is known
    initial begin
        wait (limit_clocks != 0);
        #(limit_clocks * 40);
        $display("timeout: run went past %0d clocks without finishing", limit_clocks);
        $display("Errors found");
        $finish;
    end

    task automatic load_rows();
        int    fd;
        int    n;
        int    total;
        string line;
        fd = $fopen("tests/comp_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tests/comp_testdata.txt");
            $display("Errors found");
            $finish;
        end
        total = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                        row_f[n_rows][0], row_f[n_rows][1], row_f[n_rows][2],
                        row_f[n_rows][3], row_f[n_rows][4], row_f[n_rows][5],
                        row_f[n_rows][6], row_f[n_rows][7], row_f[n_rows][8],
                        row_f[n_rows][9], row_f[n_rows][10], row_f[n_rows][11]);
            if (n == 12) begin  // comment and blank lines fall through
                total += (row_f[n_rows][3] - row_f[n_rows][2] + 1) * row_f[n_rows][4];
                n_rows++;
            end
        end
        $fclose(fd);
        limit_clocks = total + 4 + 100;  // reset, pipeline drain and margin
    endtask

    task automatic drive_row(input int i);
        for (int x = row_f[i][2]; x <= row_f[i][3]; x++) begin
            for (int h = 0; h < row_f[i][4]; h++) begin
                @(posedge clk_col16x);
                chip        <= chip_e'(row_f[i][0]);
                raster_y    <= 9'(row_f[i][1]);
                raster_x    <= 10'(x);
                white_line  <= row_f[i][5][0];
                luma_reg    <= 6'(row_f[i][6]);
                phase_reg   <= 8'(row_f[i][7]);
                amp_reg     <= 4'(row_f[i][8]);
                exp_valid_c <= 1'b1;
                exp_luma_c  <= 6'(row_f[i][9]);
                exp_sink_c  <= row_f[i][10][0];
                exp_mod_c   <= row_f[i][11][0];
                exp_seg_c   <= 8'(i);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        chip        = ntsc_r8;
        raster_x    = 10'd0;
        raster_y    = 9'd0;
        white_line  = 1'b0;
        luma_reg    = 6'd0;
        phase_reg   = 8'd0;
        amp_reg     = 4'd0;
        exp_valid_c = 1'b0;
        exp_luma_c  = 6'd0;
        exp_sink_c  = 1'b0;
        exp_mod_c   = 1'b0;
        exp_seg_c   = 8'd0;
        for (int i = 1; i <= 5; i++) begin
            exp_valid[i] = 1'b0;
            exp_luma[i]  = 6'd0;
            exp_sink[i]  = 1'b0;
            exp_mod[i]   = 1'b0;
            exp_seg[i]   = 8'd0;
        end
        load_rows();
        repeat (4) @(posedge clk_col16x);
        reset <= 1'b0;
        for (int i = 0; i < n_rows; i++)
            drive_row(i);
        @(posedge clk_col16x);
        exp_valid_c <= 1'b0;
        repeat (8) @(posedge clk_col16x);  // let the last samples reach the checker
        @(negedge clk_col16x);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end
endmodule

// File: tests/comp_testdata.txt
# chip line x_start x_end hold white_line luma_reg phase_reg amp_reg exp_luma exp_sink mod
# chip 0 ntsc_r8, 1 pal_r1, 3 pal_r3; mod 1 = modulated chroma, 0 = flat 32
0 5 0 7 1 1 40 0 0 24 0 0
0 5 8 44 1 1 40 0 0 0 1 0
0 5 45 50 1 1 40 0 0 24 0 0
0 5 51 59 16 1 40 0 0 24 0 1
0 5 60 95 1 1 40 0 0 24 0 0
0 5 96 96 1 1 40 0 0 59 0 0
0 5 97 100 16 1 40 40 10 40 0 1
0 5 101 104 4 1 40 40 0 40 0 0
0 6 96 99 4 0 20 0 0 20 0 0
0 6 100 107 16 0 63 200 15 63 0 1
0 6 108 111 1 0 63 200 0 63 0 0
0 14 0 7 1 0 40 0 0 24 0 0
0 14 8 25 1 0 40 0 0 0 1 0
0 14 26 39 1 0 40 0 0 24 0 0
0 14 40 57 1 0 40 0 0 0 1 0
0 14 58 70 1 0 40 0 0 24 0 0
0 17 0 7 1 0 40 0 0 24 0 0
0 17 8 37 1 0 40 0 0 0 1 0
0 17 38 39 1 0 40 0 0 24 0 0
0 17 40 69 1 0 40 0 0 0 1 0
0 17 70 200 1 0 40 0 0 24 0 0
1 301 0 6 1 0 40 0 0 8 0 0
1 301 7 24 1 0 40 0 0 0 1 0
1 301 25 38 1 0 40 0 0 8 0 0
1 301 39 56 1 0 40 0 0 0 1 0
1 301 57 60 1 0 40 0 0 8 0 0
1 305 0 6 1 0 40 0 0 8 0 0
1 305 7 36 1 0 40 0 0 0 1 0
1 305 37 38 1 0 40 0 0 8 0 0
1 305 39 68 1 0 40 0 0 0 1 0
1 305 69 230 1 0 40 0 0 8 0 0
3 5 0 6 1 1 30 0 0 8 0 0
3 5 7 43 1 1 30 0 0 0 1 0
3 5 44 49 1 1 30 0 0 8 0 0
3 5 50 58 16 1 30 0 0 8 0 1
3 5 59 90 1 1 30 0 0 8 0 0
3 5 91 91 1 1 30 0 0 59 0 0
3 5 92 95 16 1 30 70 9 30 0 1
3 6 92 95 16 0 30 70 7 30 0 1
3 6 96 104 16 0 12 70 0 12 0 0

// File: all.f
hdl/vid_pkg.sv
hdl/raster_if.sv
hdl/raster_window.sv
hdl/luma_gen.sv
hdl/chroma_gen.sv
hdl/composite_mix.sv
hdl/comp_video_top.sv
tests/comp_checker.sv
tests/tb_comp_video.sv

// File: run_sim.sh
#!/bin/sh
# build and run the composite video testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_comp_video -o tb_comp_video
./obj_dir/tb_comp_video > sim.log
cat sim.log
if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
